/* logic/surfturf_pkg.sv */
`default_nettype none

package surfturf_pkg;

    // register bus widths
    localparam int ADR_W = 12;
    localparam int DAT_W = 32;

    // address map: eight 64-byte slots, bit 11 selects the command core
    localparam int SLOT_SEL_LSB     = 6;
    localparam int SLOT_COUNT       = 8;
    localparam int SLOT_W           = $clog2(SLOT_COUNT);
    localparam int SPLICE_SPACE_BIT = 11;

    // word index within a slot comes from address bits 5:2
    localparam int REG_IDX_LSB = 2;
    localparam int REG_IDX_W   = 4;

    localparam logic [REG_IDX_W-1:0] REG_CTRL   = 'd0;
    localparam logic [REG_IDX_W-1:0] REG_RUNCMD = 'd1;
    localparam logic [REG_IDX_W-1:0] REG_TRIG   = 'd2;
    localparam logic [REG_IDX_W-1:0] REG_FW     = 'd3;
    localparam logic [REG_IDX_W-1:0] REG_STATUS = 'd4;

    localparam logic [REG_IDX_W-1:0] ST_LOCKED    = 'd0;
    localparam logic [REG_IDX_W-1:0] ST_LAST_CMD  = 'd1;
    localparam logic [REG_IDX_W-1:0] ST_CMD_COUNT = 'd2;

    // local command payloads
    typedef logic [1:0]  runcmd_t;
    typedef logic [14:0] trig_t;
    typedef struct packed {
        logic       mark;
        logic [7:0] data;
    } fw_t;
    typedef logic pps_t;

    // spliced word layout, shared with the TURF command word
    localparam int SPL_RUNCMD_LSB   = 0;
    localparam int SPL_TRIG_LSB     = 2;
    localparam int SPL_FW_LSB       = 17;
    localparam int SPL_FW_VALID_BIT = 25;
    localparam int SPL_FW_MARK_BIT  = 26;
    localparam int SPL_FW_GROUP_W   = 10;
    localparam int SPL_PPS_BIT      = 27;
    localparam int SPL_ZERO_LSB     = 28;

endpackage

`default_nettype wire

/* logic/wb_bus_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface wb_bus_if;
    import surfturf_pkg::*;

    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat_w;
    logic [DAT_W-1:0] dat_r;
    logic             ack;

    // master holds its request until ack
    modport master (
        output cyc, stb, we, adr, dat_w,
        input  dat_r, ack
    );

    // slave acks one cycle after stb with dat_r valid alongside
    modport slave (
        input  cyc, stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface

`default_nettype wire

/* logic/cmd_field_hold.sv */
`timescale 1ns/1ns
`default_nettype none

module cmd_field_hold #(
    parameter type payload_t = logic
) (
    input  logic     sysclk_i,
    input  logic     rst_n_i,
    input  logic     load_i,
    input  payload_t value_i,
    input  logic     take_i,
    output logic     pending_o,
    output payload_t value_o,
    output logic     overflow_o
);

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pending_o  <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            // a load alongside a take stays pending
            pending_o <= load_i | (pending_o & !take_i);
            // pending value replaced before it left
            if (load_i && pending_o && !take_i) begin
                overflow_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (load_i) begin
            value_o <= value_i;
        end
    end

endmodule

`default_nettype wire

/* logic/wb_addr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_addr_decode (
    input  logic                             sysclk_i,
    input  logic                             rst_n_i,
    input  logic                             wb_cyc_i,
    input  logic                             wb_stb_i,
    input  logic                             wb_we_i,
    input  logic [surfturf_pkg::ADR_W-1:0]   wb_adr_i,
    input  logic [surfturf_pkg::DAT_W-1:0]   wb_dat_i,
    output logic [surfturf_pkg::DAT_W-1:0]   wb_dat_o,
    output logic                             wb_ack_o,
    wb_bus_if.master                         core_o,
    wb_bus_if.master                         slot0_o
);
    import surfturf_pkg::*;

    logic              req;
    logic              splice_sel;
    logic [SLOT_W-1:0] slot;
    logic              nomap_sel;
    logic              nomap_ack;

    assign req        = wb_cyc_i & wb_stb_i;
    assign splice_sel = wb_adr_i[SPLICE_SPACE_BIT];
    assign slot       = wb_adr_i[SLOT_SEL_LSB +: SLOT_W];
    // slots 1 to 7 have no PHY behind them
    assign nomap_sel  = !splice_sel && (slot != '0);

    assign core_o.cyc   = wb_cyc_i;
    assign core_o.stb   = req & splice_sel;
    assign core_o.we    = wb_we_i;
    assign core_o.adr   = wb_adr_i;
    assign core_o.dat_w = wb_dat_i;

    assign slot0_o.cyc   = wb_cyc_i;
    assign slot0_o.stb   = req & !splice_sel & (slot == '0);
    assign slot0_o.we    = wb_we_i;
    assign slot0_o.adr   = wb_adr_i;
    assign slot0_o.dat_w = wb_dat_i;

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            nomap_ack <= 1'b0;
        end else begin
            nomap_ack <= req & nomap_sel & !nomap_ack;
        end
    end

    // return path, the address is held until ack
    always_comb begin
        if (splice_sel) begin
            wb_ack_o = core_o.ack;
            wb_dat_o = core_o.dat_r;
        end else if (slot == '0) begin
            wb_ack_o = slot0_o.ack;
            wb_dat_o = slot0_o.dat_r;
        end else begin
            wb_ack_o = nomap_ack;
            wb_dat_o = '0;
        end
    end

endmodule

`default_nettype wire

/* logic/surfturf_register_core.sv */
`timescale 1ns/1ns
`default_nettype none

module surfturf_register_core (
    input  logic                  sysclk_i,
    input  logic                  rst_n_i,
    wb_bus_if.slave               bus_i,
    output logic                  runcmd_stb_o,
    output surfturf_pkg::runcmd_t runcmd_o,
    output logic                  trig_stb_o,
    output surfturf_pkg::trig_t   trig_o,
    output logic                  fw_stb_o,
    output surfturf_pkg::fw_t     fw_o,
    input  logic                  fw_marked_i,
    input  logic [2:0]            overflow_i,
    output logic                  disable_rxclk_o
);
    import surfturf_pkg::*;

    logic                 ack_q;
    logic                 accept;
    logic                 wr;
    logic [REG_IDX_W-1:0] reg_idx;
    logic [DAT_W-1:0]     rd_data;
    logic [DAT_W-1:0]     dat_r_q;
    logic                 fw_marked_q;

    assign accept  = bus_i.cyc & bus_i.stb & !ack_q;
    assign wr      = accept & bus_i.we;
    assign reg_idx = bus_i.adr[REG_IDX_LSB +: REG_IDX_W];

    assign bus_i.ack   = ack_q;
    assign bus_i.dat_r = dat_r_q;

    always_comb begin
        rd_data = '0;
        case (reg_idx)
            REG_CTRL:   rd_data[0] = disable_rxclk_o;
            REG_RUNCMD: rd_data[$bits(runcmd_t)-1:0] = runcmd_o;
            REG_TRIG:   rd_data[$bits(trig_t)-1:0] = trig_o;
            REG_FW:     rd_data[$bits(fw_t)-1:0] = fw_o;
            // sticky marked flag, then the three overflow bits
            REG_STATUS: rd_data[3:0] = {overflow_i, fw_marked_q};
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q           <= 1'b0;
            dat_r_q         <= '0;
            runcmd_stb_o    <= 1'b0;
            trig_stb_o      <= 1'b0;
            fw_stb_o        <= 1'b0;
            disable_rxclk_o <= 1'b0;
            fw_marked_q     <= 1'b0;
        end else begin
            ack_q        <= accept;
            runcmd_stb_o <= wr && (reg_idx == REG_RUNCMD);
            trig_stb_o   <= wr && (reg_idx == REG_TRIG);
            fw_stb_o     <= wr && (reg_idx == REG_FW);
            if (accept) begin
                dat_r_q <= rd_data;
            end
            if (wr && (reg_idx == REG_CTRL)) begin
                disable_rxclk_o <= bus_i.dat_w[0];
            end
            // a new marked byte wins over a clear in the same cycle
            if (fw_marked_i) begin
                fw_marked_q <= 1'b1;
            end else if (wr && (reg_idx == REG_STATUS)) begin
                fw_marked_q <= 1'b0;
            end
        end
    end

    // payloads launched alongside the strobes
    always_ff @(posedge sysclk_i) begin
        if (wr && (reg_idx == REG_RUNCMD)) begin
            runcmd_o <= runcmd_t'(bus_i.dat_w[$bits(runcmd_t)-1:0]);
        end
        if (wr && (reg_idx == REG_TRIG)) begin
            trig_o <= trig_t'(bus_i.dat_w[$bits(trig_t)-1:0]);
        end
        if (wr && (reg_idx == REG_FW)) begin
            fw_o <= fw_t'(bus_i.dat_w[$bits(fw_t)-1:0]);
        end
    end

endmodule

`default_nettype wire

/* logic/turfio_cmd_splice.sv */
`timescale 1ns/1ns
`default_nettype none

module turfio_cmd_splice (
    input  logic                           sysclk_i,
    input  logic                           rst_n_i,
    input  logic                           sync_i,
    input  logic [surfturf_pkg::DAT_W-1:0] command_i,
    input  logic                           command_valid_i,
    input  logic                           command_locked_i,
    input  logic                           runcmd_stb_i,
    input  surfturf_pkg::runcmd_t          runcmd_i,
    input  logic                           trig_stb_i,
    input  surfturf_pkg::trig_t            trig_i,
    input  logic                           fw_stb_i,
    input  surfturf_pkg::fw_t              fw_i,
    input  logic                           tfio_pps_i,
    input  logic                           use_tfio_pps_i,
    output logic [surfturf_pkg::DAT_W-1:0] spliced_o,
    output logic                           spliced_valid_o,
    output logic                           fw_marked_o,
    output logic [2:0]                     overflow_o
);
    import surfturf_pkg::*;

    runcmd_t          runcmd_val;
    trig_t            trig_val;
    fw_t              fw_val;
    pps_t             pps_val;
    logic             runcmd_pend;
    logic             trig_pend;
    logic             fw_pend;
    logic             pps_pend;
    logic             pps_q;
    logic             pps_load;
    logic [DAT_W-1:0] turf_q;
    logic             turf_pend;
    logic [DAT_W-1:0] next_word;

    // rising edge of the local pps, only when it is the selected source
    assign pps_load = tfio_pps_i & !pps_q & use_tfio_pps_i;

    cmd_field_hold #(.payload_t(runcmd_t)) u_runcmd (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i), .load_i(runcmd_stb_i), .value_i(runcmd_i),
        .take_i(sync_i), .pending_o(runcmd_pend), .value_o(runcmd_val),
        .overflow_o(overflow_o[0]));
    cmd_field_hold #(.payload_t(trig_t)) u_trig (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i), .load_i(trig_stb_i), .value_i(trig_i),
        .take_i(sync_i), .pending_o(trig_pend), .value_o(trig_val),
        .overflow_o(overflow_o[1]));
    cmd_field_hold #(.payload_t(fw_t)) u_fw (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i), .load_i(fw_stb_i), .value_i(fw_i),
        .take_i(sync_i), .pending_o(fw_pend), .value_o(fw_val),
        .overflow_o(overflow_o[2]));
    cmd_field_hold #(.payload_t(pps_t)) u_pps (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i), .load_i(pps_load), .value_i(1'b1),
        .take_i(sync_i), .pending_o(pps_pend), .value_o(pps_val),
        .overflow_o());

    // field precedence: local pending, then captured TURF command, then zero
    always_comb begin
        next_word = '0;
        if (runcmd_pend) begin
            next_word[SPL_RUNCMD_LSB +: $bits(runcmd_t)] = runcmd_val;
        end else if (turf_pend) begin
            next_word[SPL_RUNCMD_LSB +: $bits(runcmd_t)] =
                turf_q[SPL_RUNCMD_LSB +: $bits(runcmd_t)];
        end
        if (trig_pend) begin
            next_word[SPL_TRIG_LSB +: $bits(trig_t)] = trig_val;
        end else if (turf_pend) begin
            next_word[SPL_TRIG_LSB +: $bits(trig_t)] = turf_q[SPL_TRIG_LSB +: $bits(trig_t)];
        end
        if (fw_pend) begin
            next_word[SPL_FW_LSB +: 8]    = fw_val.data;
            next_word[SPL_FW_VALID_BIT] = 1'b1;
            next_word[SPL_FW_MARK_BIT]  = fw_val.mark;
        end else if (turf_pend) begin
            next_word[SPL_FW_LSB +: SPL_FW_GROUP_W] = turf_q[SPL_FW_LSB +: SPL_FW_GROUP_W];
        end
        if (pps_pend) begin
            next_word[SPL_PPS_BIT] = pps_val;
        end else if (turf_pend) begin
            next_word[SPL_PPS_BIT] = turf_q[SPL_PPS_BIT];
        end
    end

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pps_q           <= 1'b0;
            turf_pend       <= 1'b0;
            spliced_o       <= '0;
            spliced_valid_o <= 1'b0;
            fw_marked_o     <= 1'b0;
        end else begin
            pps_q <= tfio_pps_i;
            // a fresh capture waits for the following sync
            if (command_valid_i && command_locked_i) begin
                turf_pend <= 1'b1;
            end else if (sync_i) begin
                turf_pend <= 1'b0;
            end
            if (sync_i) begin
                spliced_o <= {{(DAT_W-SPL_ZERO_LSB){1'b0}}, next_word[SPL_ZERO_LSB-1:0]};
            end
            spliced_valid_o <= sync_i;
            fw_marked_o     <= sync_i & fw_pend & fw_val.mark;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (command_valid_i && command_locked_i) begin
            turf_q <= command_i;
        end
    end

endmodule

`default_nettype wire

/* logic/turf_status_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module turf_status_regs (
    input  logic                           sysclk_i,
    input  logic                           rst_n_i,
    wb_bus_if.slave                        bus_i,
    input  logic [surfturf_pkg::DAT_W-1:0] command_i,
    input  logic                           command_valid_i,
    input  logic                           command_locked_i
);
    import surfturf_pkg::*;

    logic                 ack_q;
    logic                 accept;
    logic [REG_IDX_W-1:0] reg_idx;
    logic [DAT_W-1:0]     rd_data;
    logic [DAT_W-1:0]     dat_r_q;
    logic                 locked_q;
    logic [DAT_W-1:0]     last_cmd_q;
    logic [DAT_W-1:0]     cmd_count_q;

    // writes are acked like reads and have no effect
    assign accept  = bus_i.cyc & bus_i.stb & !ack_q;
    assign reg_idx = bus_i.adr[REG_IDX_LSB +: REG_IDX_W];

    assign bus_i.ack   = ack_q;
    assign bus_i.dat_r = dat_r_q;

    always_comb begin
        case (reg_idx)
            ST_LOCKED:    rd_data = {{(DAT_W-1){1'b0}}, locked_q};
            ST_LAST_CMD:  rd_data = last_cmd_q;
            ST_CMD_COUNT: rd_data = cmd_count_q;
            default:      rd_data = '0;
        endcase
    end

    always_ff @(posedge sysclk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q       <= 1'b0;
            dat_r_q     <= '0;
            locked_q    <= 1'b0;
            last_cmd_q  <= '0;
            cmd_count_q <= '0;
        end else begin
            ack_q    <= accept;
            locked_q <= command_locked_i;
            if (accept) begin
                dat_r_q <= rd_data;
            end
            if (command_valid_i && command_locked_i) begin
                last_cmd_q  <= command_i;
                cmd_count_q <= cmd_count_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/surfturf_wrapper.sv */
`timescale 1ns/1ns
`default_nettype none

module surfturf_wrapper (
    input  logic                           sysclk_i,
    input  logic                           rst_n_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [surfturf_pkg::ADR_W-1:0] wb_adr_i,
    input  logic [surfturf_pkg::DAT_W-1:0] wb_dat_i,
    output logic [surfturf_pkg::DAT_W-1:0] wb_dat_o,
    output logic                           wb_ack_o,
    input  logic                           sync_i,
    input  logic [surfturf_pkg::DAT_W-1:0] command_i,
    input  logic                           command_valid_i,
    input  logic                           command_locked_i,
    input  logic                           tfio_pps_i,
    input  logic                           use_tfio_pps_i,
    output logic [surfturf_pkg::DAT_W-1:0] spliced_o,
    output logic                           spliced_valid_o,
    output logic                           disable_rxclk_o
);
    import surfturf_pkg::*;

    wb_bus_if core_bus ();
    wb_bus_if slot0_bus ();

    logic       runcmd_stb;
    runcmd_t    runcmd;
    logic       trig_stb;
    trig_t      trig;
    logic       fw_stb;
    fw_t        fw;
    logic       fw_marked;
    logic [2:0] overflow;

    wb_addr_decode u_decode (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .core_o(core_bus.master), .slot0_o(slot0_bus.master));

    surfturf_register_core u_st_core (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i), .bus_i(core_bus.slave),
        .runcmd_stb_o(runcmd_stb), .runcmd_o(runcmd),
        .trig_stb_o(trig_stb), .trig_o(trig),
        .fw_stb_o(fw_stb), .fw_o(fw),
        .fw_marked_i(fw_marked), .overflow_i(overflow),
        .disable_rxclk_o(disable_rxclk_o));

    // slot 0 stands in for the TURF link
    turf_status_regs u_turf (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i), .bus_i(slot0_bus.slave),
        .command_i(command_i), .command_valid_i(command_valid_i),
        .command_locked_i(command_locked_i));

    turfio_cmd_splice u_splice (
        .sysclk_i(sysclk_i), .rst_n_i(rst_n_i), .sync_i(sync_i),
        .command_i(command_i), .command_valid_i(command_valid_i),
        .command_locked_i(command_locked_i),
        .runcmd_stb_i(runcmd_stb), .runcmd_i(runcmd),
        .trig_stb_i(trig_stb), .trig_i(trig),
        .fw_stb_i(fw_stb), .fw_i(fw),
        .tfio_pps_i(tfio_pps_i), .use_tfio_pps_i(use_tfio_pps_i),
        .spliced_o(spliced_o), .spliced_valid_o(spliced_valid_o),
        .fw_marked_o(fw_marked), .overflow_o(overflow));

endmodule

`default_nettype wire

/* dv/surfturf_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module surfturf_asserts (
    input logic                           clk_i,
    input logic                           rst_n_i,
    input logic                           ack_i,
    input logic                           sync_i,
    input logic                           valid_i,
    input logic [surfturf_pkg::DAT_W-1:0] word_i
);

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
        else $error("bus ack stayed high for more than one cycle");

    // valid is the sync pulse delayed by one cycle
    valid_after_sync: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i == $past(sync_i))
        else $error("spliced valid does not follow sync by one cycle");

    top_bits_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        word_i[31:28] == 4'h0)
        else $error("spliced word has nonzero bits 31:28");

endmodule

bind wb_addr_decode surfturf_asserts u_decode_asserts (
    .clk_i(sysclk_i), .rst_n_i(rst_n_i), .ack_i(wb_ack_o),
    .sync_i(1'b0), .valid_i(1'b0), .word_i(32'h0));

bind turfio_cmd_splice surfturf_asserts u_splice_asserts (
    .clk_i(sysclk_i), .rst_n_i(rst_n_i), .ack_i(1'b0),
    .sync_i(sync_i), .valid_i(spliced_valid_o), .word_i(spliced_o));

`default_nettype wire

/* dv/surfturf_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module surfturf_tb;
    import surfturf_pkg::*;

    localparam int K_WR   = 0;
    localparam int K_RD   = 1;
    localparam int K_TURF = 2;
    localparam int K_PPS  = 3;
    localparam int K_SYNC = 4;
    localparam int MAX_STEPS = 64;
    localparam int TIMEOUT   = 20;

    logic             sysclk;
    logic             rst_n;
    logic             wb_cyc;
    logic             wb_stb;
    logic             wb_we;
    logic [ADR_W-1:0] wb_adr;
    logic [DAT_W-1:0] wb_dat_w;
    logic [DAT_W-1:0] wb_dat_r;
    logic             wb_ack;
    logic             sync;
    logic [DAT_W-1:0] command;
    logic             command_valid;
    logic             command_locked;
    logic             tfio_pps;
    logic             use_tfio_pps;
    logic [DAT_W-1:0] spliced;
    logic             spliced_valid;
    logic             disable_rxclk;

    // stimulus table
    // TURF and pps steps carry locked or use in address bit 0
    int               st_kind [MAX_STEPS];
    logic [ADR_W-1:0] st_adr  [MAX_STEPS];
    logic [DAT_W-1:0] st_dat  [MAX_STEPS];
    logic [DAT_W-1:0] st_exp  [MAX_STEPS];
    int               n_steps;
    int               n_checks;
    int               n_errors;
    logic             timed_out;
    integer           seed;

    // reference model state
    logic             m_run_pend;
    logic [1:0]       m_run;
    logic             m_trig_pend;
    logic [14:0]      m_trig;
    logic             m_fw_pend;
    logic [8:0]       m_fw;
    logic             m_pps_pend;
    logic             m_turf_pend;
    logic [DAT_W-1:0] m_turf;

    surfturf_wrapper dut0 (
        .sysclk_i(sysclk), .rst_n_i(rst_n),
        .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
        .wb_dat_i(wb_dat_w), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
        .sync_i(sync), .command_i(command), .command_valid_i(command_valid),
        .command_locked_i(command_locked), .tfio_pps_i(tfio_pps),
        .use_tfio_pps_i(use_tfio_pps), .spliced_o(spliced),
        .spliced_valid_o(spliced_valid), .disable_rxclk_o(disable_rxclk));

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;
    end

    function automatic logic [ADR_W-1:0] core_adr(input logic [3:0] idx);
        return ADR_W'((1 << SPLICE_SPACE_BIT) | (int'(idx) << 2));
    endfunction

    function automatic logic [ADR_W-1:0] slot_adr(input int slot, input int idx);
        return ADR_W'((slot << SLOT_SEL_LSB) | (idx << 2));
    endfunction

    task automatic finish_run();
        $display("checks: %0d errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("[ERROR] %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        timed_out = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    // local fields win over the captured TURF command, field by field
    task automatic model_sync(output logic [31:0] word);
        word = '0;
        if (m_run_pend) word[1:0] = m_run;
        else if (m_turf_pend) word[1:0] = m_turf[1:0];
        if (m_trig_pend) word[16:2] = m_trig;
        else if (m_turf_pend) word[16:2] = m_turf[16:2];
        if (m_fw_pend) begin
            word[24:17] = m_fw[7:0];
            word[25]    = 1'b1;
            word[26]    = m_fw[8];
        end else if (m_turf_pend) begin
            word[26:17] = m_turf[26:17];
        end
        if (m_pps_pend) word[27] = 1'b1;
        else if (m_turf_pend) word[27] = m_turf[27];
        m_run_pend  = 1'b0;
        m_trig_pend = 1'b0;
        m_fw_pend   = 1'b0;
        m_pps_pend  = 1'b0;
        m_turf_pend = 1'b0;
    endtask

    task automatic model_update(input int kind, input logic [ADR_W-1:0] adr,
                                input logic [31:0] dat);
        if (kind == K_WR && adr == core_adr(REG_RUNCMD)) begin
            m_run_pend = 1'b1;
            m_run      = dat[1:0];
        end else if (kind == K_WR && adr == core_adr(REG_TRIG)) begin
            m_trig_pend = 1'b1;
            m_trig      = dat[14:0];
        end else if (kind == K_WR && adr == core_adr(REG_FW)) begin
            m_fw_pend = 1'b1;
            m_fw      = dat[8:0];
        end else if (kind == K_TURF && adr[0]) begin
            m_turf_pend = 1'b1;
            m_turf      = dat;
        end else if (kind == K_PPS && adr[0]) begin
            m_pps_pend = 1'b1;
        end
    endtask

    // sync steps take their expected word from the model as the table is built
    task automatic add_step(input int kind, input logic [ADR_W-1:0] adr,
                            input logic [31:0] dat, input logic [31:0] exp);
        logic [31:0] word;
        word = exp;
        if (kind == K_SYNC) model_sync(word);
        else model_update(kind, adr, dat);
        st_kind[n_steps] = kind;
        st_adr[n_steps]  = adr;
        st_dat[n_steps]  = dat;
        st_exp[n_steps]  = word;
        n_steps++;
    endtask

    task automatic build_table();
        logic [31:0] c1;
        logic [31:0] c2;
        logic [31:0] c3;
        logic [31:0] t1;
        logic [31:0] fwb;
        c1  = $random(seed);
        c2  = $random(seed) & 32'h0fff_ffff;
        c3  = $random(seed);
        t1  = $random(seed) & 32'h0000_7fff;
        fwb = 32'h100 | ($random(seed) & 32'hff);
        // register access and the unmapped slots
        add_step(K_WR, core_adr(REG_CTRL), 32'h1, 32'h1);
        add_step(K_RD, core_adr(REG_CTRL), 32'h0, 32'h1);
        add_step(K_WR, core_adr(REG_CTRL), 32'h0, 32'h0);
        add_step(K_RD, core_adr(REG_CTRL), 32'h0, 32'h0);
        for (int s = 1; s < SLOT_COUNT; s++) begin
            add_step(K_RD, slot_adr(s, $random(seed) & 15), 32'h0, 32'h0);
        end
        // local fields and a marked firmware byte that sets the status flag
        add_step(K_WR, core_adr(REG_RUNCMD), 32'h2, 32'h0);
        add_step(K_SYNC, '0, 32'h0, 32'h0);
        add_step(K_WR, core_adr(REG_TRIG), t1, 32'h0);
        add_step(K_SYNC, '0, 32'h0, 32'h0);
        add_step(K_WR, core_adr(REG_FW), fwb, 32'h0);
        add_step(K_SYNC, '0, 32'h0, 32'h0);
        add_step(K_RD, core_adr(REG_STATUS), 32'h0, 32'h1);
        add_step(K_WR, core_adr(REG_STATUS), 32'h0, 32'h0);
        add_step(K_RD, core_adr(REG_STATUS), 32'h0, 32'h0);
        // TURF pass-through, then an unlocked command
        add_step(K_TURF, 12'h1, c1, 32'h0);
        add_step(K_SYNC, '0, 32'h0, 32'h0);
        add_step(K_RD, slot_adr(0, int'(ST_LOCKED)), 32'h0, 32'h1);
        add_step(K_TURF, 12'h0, c2, 32'h0);
        add_step(K_SYNC, '0, 32'h0, 32'h0);
        // local trigger against a TURF command
        add_step(K_WR, core_adr(REG_TRIG), $random(seed) & 32'h7fff, 32'h0);
        add_step(K_TURF, 12'h1, c3, 32'h0);
        add_step(K_SYNC, '0, 32'h0, 32'h0);
        // trigger overflow, then pps with and without use
        add_step(K_WR, core_adr(REG_TRIG), $random(seed) & 32'h7fff, 32'h0);
        add_step(K_WR, core_adr(REG_TRIG), $random(seed) & 32'h7fff, 32'h0);
        add_step(K_SYNC, '0, 32'h0, 32'h0);
        add_step(K_RD, core_adr(REG_STATUS), 32'h0, 32'h4);
        add_step(K_PPS, 12'h1, 32'h0, 32'h0);
        add_step(K_SYNC, '0, 32'h0, 32'h0);
        add_step(K_PPS, 12'h0, 32'h0, 32'h0);
        add_step(K_SYNC, '0, 32'h0, 32'h0);
        // slot 0 counters only see the locked commands c1 and c3
        add_step(K_RD, slot_adr(0, int'(ST_CMD_COUNT)), 32'h0, 32'h2);
        add_step(K_RD, slot_adr(0, int'(ST_LAST_CMD)), 32'h0, c3);
    endtask

    task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
                             input logic [31:0] dat, output logic [31:0] rdata);
        int   cnt;
        logic seen;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat;
        cnt = 0;
        do begin
            @(posedge sysclk);
            #10;
            cnt++;
        end while (!wb_ack && cnt < TIMEOUT);
        seen   = wb_ack;
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!seen) begin
            report_timeout("bus ack");
        end else begin
            check_value("wb_ack_latency", 32'(cnt), 32'h1);
        end
    endtask

    task automatic run_sync(output logic [31:0] word);
        int cnt;
        sync = 1'b1;
        @(posedge sysclk);
        #10;
        sync = 1'b0;
        cnt  = 0;
        while (!spliced_valid && cnt < TIMEOUT) begin
            @(posedge sysclk);
            #10;
            cnt++;
        end
        if (!spliced_valid) report_timeout("spliced_valid_o");
        word = spliced;
    endtask

    task automatic send_turf(input logic [31:0] cmd, input logic locked);
        command        = cmd;
        command_valid  = 1'b1;
        command_locked = locked;
        @(posedge sysclk);
        #10;
        command_valid = 1'b0;
    endtask

    task automatic pulse_pps(input logic use_pps);
        use_tfio_pps = use_pps;
        tfio_pps     = 1'b1;
        @(posedge sysclk);
        #10;
        tfio_pps = 1'b0;
    endtask

    initial begin
        logic [31:0] rdata;
        seed = 67;
        n_steps   = 0;
        n_checks  = 0;
        n_errors  = 0;
        timed_out = 1'b0;
        {m_run_pend, m_trig_pend, m_fw_pend, m_pps_pend, m_turf_pend} = '0;
        m_run  = '0;
        m_trig = '0;
        m_fw   = '0;
        m_turf = '0;
        rst_n          = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        sync           = 1'b0;
        command        = '0;
        command_valid  = 1'b0;
        command_locked = 1'b0;
        tfio_pps       = 1'b0;
        use_tfio_pps   = 1'b0;
        build_table();
        repeat (5) @(posedge sysclk);
        #10;
        rst_n = 1'b1;
        check_value("spliced_o", spliced, 32'h0);
        check_value("spliced_valid_o", {31'b0, spliced_valid}, 32'h0);
        check_value("wb_ack_o", {31'b0, wb_ack}, 32'h0);
        check_value("disable_rxclk_o", {31'b0, disable_rxclk}, 32'h0);
        for (int i = 0; i < n_steps; i++) begin
            case (st_kind[i])
                K_WR: begin
                    bus_cycle(1'b1, st_adr[i], st_dat[i], rdata);
                    if (st_adr[i] == core_adr(REG_CTRL)) begin
                        check_value("disable_rxclk_o", {31'b0, disable_rxclk}, st_exp[i]);
                    end
                end
                K_RD: begin
                    bus_cycle(1'b0, st_adr[i], 32'h0, rdata);
                    check_value("wb_dat_o", rdata, st_exp[i]);
                end
                K_TURF: send_turf(st_dat[i], st_adr[i][0]);
                K_PPS:  pulse_pps(st_adr[i][0]);
                default: begin
                    run_sync(rdata);
                    check_value("spliced_o", rdata, st_exp[i]);
                end
            endcase
            if (timed_out) begin
                break;
            end
            // one idle cycle lets strobes reach the holders and flags
            @(posedge sysclk);
            #10;
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* files.f */
logic/surfturf_pkg.sv
logic/wb_bus_if.sv
logic/cmd_field_hold.sv
logic/wb_addr_decode.sv
logic/surfturf_register_core.sv
logic/turfio_cmd_splice.sv
logic/turf_status_regs.sv
logic/surfturf_wrapper.sv
dv/surfturf_asserts.sv
dv/surfturf_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= surfturf_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
